// ==== Makefile ====
TOP = tb_ex_stage

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== alu/ex_alu.sv ====
module ex_alu (
    input  ex_pkg::aluop_e          aluop_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] oprand1_i,
    input  logic [ex_pkg::XLEN-1:0] oprand2_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);
    import ex_pkg::*;

    logic [$clog2(XLEN)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    // Shift amount from the low bits of operand 2
    assign shamt = oprand2_i[$clog2(XLEN)-1:0];

    assign lt_signed   = $signed(oprand1_i) < $signed(oprand2_i);
    assign lt_unsigned = oprand1_i < oprand2_i;

    always_comb begin
        case (aluop_i)
            // Logic
            OP_AND: begin
                result_o = oprand1_i & oprand2_i;
            end
            OP_OR: begin
                result_o = oprand1_i | oprand2_i;
            end
            OP_XOR: begin
                result_o = oprand1_i ^ oprand2_i;
            end
            OP_NOR: begin
                result_o = ~(oprand1_i | oprand2_i);
            end
            // Shift
            OP_SLL: begin
                result_o = oprand1_i << shamt;
            end
            OP_SRL: begin
                result_o = oprand1_i >> shamt;
            end
            OP_SRA: begin
                result_o = $unsigned($signed(oprand1_i) >>> shamt);
            end
            // Arithmetic and compare
            OP_ADD: begin
                result_o = oprand1_i + oprand2_i;
            end
            OP_SUB: begin
                result_o = oprand1_i - oprand2_i;
            end
            OP_SLT: begin
                result_o = XLEN'(lt_signed);
            end
            OP_SLTU: begin
                result_o = XLEN'(lt_unsigned);
            end
            // Move, immediate already shifted by decode
            OP_LUI: begin
                result_o = oprand2_i;
            end
            OP_PCADD: begin
                result_o = pc_i + oprand2_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== common/ex_pkg.sv ====
package ex_pkg;

    // Datapath and register file widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // Operation codes, already decoded upstream
    typedef enum logic [4:0] {
        OP_NOP,
        // Single-cycle ALU
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_LUI, OP_PCADD,
        // Multiply
        OP_MUL, OP_MULH, OP_MULHU,
        // Divide
        OP_DIV, OP_DIVU, OP_MOD, OP_MODU,
        // Branch and jump
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_B, OP_BL, OP_JIRL
    } aluop_e;

    function automatic logic is_mul(aluop_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU};
    endfunction

    function automatic logic is_div(aluop_e op);
        return op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    endfunction

    function automatic logic is_branch(aluop_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                          OP_B, OP_BL, OP_JIRL};
    endfunction

    // Jumps that write the return address
    function automatic logic is_link(aluop_e op);
        return op inside {OP_BL, OP_JIRL};
    endfunction

endpackage

// ==== hdl/branch_unit.sv ====
module branch_unit (
    input  logic                    valid_i,
    input  logic                    advance_i,
    input  ex_pkg::aluop_e          aluop_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    input  logic [ex_pkg::XLEN-1:0] oprand1_i,
    input  logic [ex_pkg::XLEN-1:0] oprand2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic                    predicted_taken_i,
    output logic                    redirect_o,
    output logic [ex_pkg::XLEN-1:0] redirect_target_o
);
    import ex_pkg::*;

    logic            cond;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] fall_through;

    always_comb begin
        case (aluop_i)
            OP_BEQ:               cond = oprand1_i == oprand2_i;
            OP_BNE:               cond = oprand1_i != oprand2_i;
            OP_BLT:               cond = $signed(oprand1_i) < $signed(oprand2_i);
            OP_BGE:               cond = $signed(oprand1_i) >= $signed(oprand2_i);
            OP_BLTU:              cond = oprand1_i < oprand2_i;
            OP_BGEU:              cond = oprand1_i >= oprand2_i;
            OP_B, OP_BL, OP_JIRL: cond = 1'b1;
            default:              cond = 1'b0;
        endcase
    end

    // Anything that is not a branch falls through
    assign taken = is_branch(aluop_i) && cond;

    // JIRL is register relative, the rest pc relative
    assign target       = (aluop_i == OP_JIRL) ? oprand1_i + imm_i : pc_i + imm_i;
    assign fall_through = pc_i + XLEN'(4);

    assign redirect_o        = valid_i && advance_i && (taken ^ predicted_taken_i);
    assign redirect_target_o = taken ? target : fall_through;

endmodule

// ==== hdl/ex_stage.sv ====
module ex_stage #(
    parameter int MULDIV_STEPS = 32
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  ex_pkg::aluop_e                  aluop_i,
    input  logic [ex_pkg::XLEN-1:0]         pc_i,
    input  logic [ex_pkg::XLEN-1:0]         oprand1_i,
    input  logic [ex_pkg::XLEN-1:0]         oprand2_i,
    input  logic [ex_pkg::XLEN-1:0]         imm_i,
    input  logic                            wreg_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic                            predicted_taken_i,
    input  logic                            advance_i,
    input  logic                            flush_i,
    output logic                            advance_ready_o,
    output logic                            out_valid_o,
    output logic                            out_wreg_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]   out_waddr_o,
    output logic [ex_pkg::XLEN-1:0]         out_wdata_o,
    output logic                            redirect_o,
    output logic [ex_pkg::XLEN-1:0]         redirect_target_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] muldiv_result;
    logic [XLEN-1:0] wdata;
    logic            muldiv_stall;

    ex_alu ex_alu_inst (
        .aluop_i   (aluop_i),
        .pc_i      (pc_i),
        .oprand1_i (oprand1_i),
        .oprand2_i (oprand2_i),
        .result_o  (alu_result)
    );

    muldiv_ctrl #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) muldiv_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_i),
        .aluop_i   (aluop_i),
        .oprand1_i (oprand1_i),
        .oprand2_i (oprand2_i),
        .advance_i (advance_i),
        .flush_i   (flush_i),
        .result_o  (muldiv_result),
        .stall_o   (muldiv_stall)
    );

    branch_unit branch_unit_inst (
        .valid_i           (valid_i),
        .advance_i         (advance_i),
        .aluop_i           (aluop_i),
        .pc_i              (pc_i),
        .oprand1_i         (oprand1_i),
        .oprand2_i         (oprand2_i),
        .imm_i             (imm_i),
        .predicted_taken_i (predicted_taken_i),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

    // Hold the pipeline while a mul/div is still running
    assign advance_ready_o = !muldiv_stall;

    // Write-back data select
    always_comb begin
        if (is_mul(aluop_i) || is_div(aluop_i)) begin
            wdata = muldiv_result;
        end else if (is_link(aluop_i)) begin
            wdata = pc_i + XLEN'(4);
        end else begin
            wdata = alu_result;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register toward MEM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_valid_o <= 1'b0;
            out_wreg_o  <= 1'b0;
        end else if (advance_i) begin
            out_valid_o <= valid_i;
            out_wreg_o  <= valid_i && wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i && !flush_i) begin
            out_waddr_o <= waddr_i;
            out_wdata_o <= wdata;
        end
    end

    // Upstream must respect the stall
    advance_only_when_ready: assert property (
        @(posedge clk) disable iff (rst) advance_i |-> advance_ready_o
    );

endmodule

// ==== muldiv/div_iter.sv ====
module div_iter #(
    parameter int MULDIV_STEPS = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  logic                    signed_i,
    input  logic [ex_pkg::XLEN-1:0] dividend_i,
    input  logic [ex_pkg::XLEN-1:0] divisor_i,
    output logic                    busy_o,
    output logic                    done_o,
    output logic [ex_pkg::XLEN-1:0] quotient_o,
    output logic [ex_pkg::XLEN-1:0] remainder_o
);
    import ex_pkg::*;

    localparam int CNT_W     = $clog2(MULDIV_STEPS + 1);
    // Fewer steps only cover the low dividend bits
    localparam int PRE_SHIFT = XLEN - MULDIV_STEPS;

    logic [XLEN-1:0]  divisor_safe;
    logic [XLEN-1:0]  dvd_mag;
    logic [XLEN-1:0]  dvs_mag;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  dvs_q;
    logic             q_neg_q;
    logic             r_neg_q;
    logic [XLEN:0]    trial;
    logic [XLEN:0]    diff;
    logic [CNT_W-1:0] step_q;
    logic             last_step;

    // Zero divisor becomes 1, quotient is the dividend
    assign divisor_safe = (divisor_i == '0) ? XLEN'(1) : divisor_i;
    assign dvd_mag = (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign dvs_mag = (signed_i && divisor_safe[XLEN-1]) ? -divisor_safe : divisor_safe;

    // Shift in the next dividend bit, try to subtract
    assign trial = {rem_q, quo_q[XLEN-1]};
    assign diff  = trial - {1'b0, dvs_q};
    assign last_step = step_q == CNT_W'(MULDIV_STEPS);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            step_q <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_o <= 1'b1;
                step_q <= '0;
            end else if (busy_o) begin
                if (last_step) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q   <= dvd_mag << PRE_SHIFT;
            rem_q   <= '0;
            dvs_q   <= dvs_mag;
            q_neg_q <= signed_i && (dividend_i[XLEN-1] ^ divisor_safe[XLEN-1]);
            r_neg_q <= signed_i && dividend_i[XLEN-1];
        end else if (busy_o) begin
            if (last_step) begin
                quotient_o  <= q_neg_q ? -quo_q : quo_q;
                remainder_o <= r_neg_q ? -rem_q : rem_q;
            end else begin
                // Restore on a negative difference
                rem_q <= diff[XLEN] ? trial[XLEN-1:0] : diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
            end
        end
    end

endmodule

// ==== muldiv/mul_iter.sv ====
module mul_iter #(
    parameter int MULDIV_STEPS = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      signed_i,
    input  logic [ex_pkg::XLEN-1:0]   a_i,
    input  logic [ex_pkg::XLEN-1:0]   b_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic [2*ex_pkg::XLEN-1:0] product_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(MULDIV_STEPS + 1);

    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [2*XLEN-1:0] mcand_q;
    logic [XLEN-1:0]   mplier_q;
    logic [2*XLEN-1:0] acc_q;
    logic [CNT_W-1:0]  step_q;
    logic              neg_q;
    logic              last_step;

    assign a_mag = (signed_i && a_i[XLEN-1]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[XLEN-1]) ? -b_i : b_i;
    assign last_step = step_q == CNT_W'(MULDIV_STEPS);

    // Step counter, one extra cycle for the sign fix
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            step_q <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_o <= 1'b1;
                step_q <= '0;
            end else if (busy_o) begin
                if (last_step) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= {{XLEN{1'b0}}, a_mag};
            mplier_q <= b_mag;
            acc_q    <= '0;
            neg_q    <= signed_i && (a_i[XLEN-1] ^ b_i[XLEN-1]);
        end else if (busy_o) begin
            if (last_step) begin
                product_o <= neg_q ? -acc_q : acc_q;
            end else begin
                if (mplier_q[0]) begin
                    acc_q <= acc_q + mcand_q;
                end
                mcand_q  <= mcand_q << 1;
                mplier_q <= mplier_q >> 1;
            end
        end
    end

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst) start_i |-> !busy_o
    );

endmodule

// ==== muldiv/muldiv_ctrl.sv ====
module muldiv_ctrl #(
    parameter int MULDIV_STEPS = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  ex_pkg::aluop_e          aluop_i,
    input  logic [ex_pkg::XLEN-1:0] oprand1_i,
    input  logic [ex_pkg::XLEN-1:0] oprand2_i,
    input  logic                    advance_i,
    input  logic                    flush_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    stall_o
);
    import ex_pkg::*;

    logic              mul_op;
    logic              div_op;
    logic              md_op;
    logic              mul_signed;
    logic              div_signed;
    logic              unit_busy;
    logic              issue;
    logic              capture;
    logic [XLEN-1:0]   capture_data;
    logic              started_q;
    logic              finished_q;
    logic              mul_start_q;
    logic              div_start_q;
    logic              mul_busy;
    logic              mul_done;
    logic [2*XLEN-1:0] product;
    logic              div_busy;
    logic              div_done;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    assign mul_op     = valid_i && is_mul(aluop_i);
    assign div_op     = valid_i && is_div(aluop_i);
    assign md_op      = mul_op || div_op;
    assign mul_signed = aluop_i != OP_MULHU;
    assign div_signed = aluop_i inside {OP_DIV, OP_MOD};

    // A run left over from a flushed instruction must drain first
    assign unit_busy = mul_op ? mul_busy : div_busy;
    assign issue = md_op && !started_q && !finished_q && !unit_busy
                   && !advance_i && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= issue && mul_op;
            div_start_q <= issue && div_op;
        end
    end

    // Only a done belonging to this instruction is taken
    assign capture = started_q && ((mul_op && mul_done) || (div_op && div_done));

    always_ff @(posedge clk) begin
        if (rst || advance_i || flush_i) begin
            started_q  <= 1'b0;
            finished_q <= 1'b0;
        end else begin
            if (issue) begin
                started_q <= 1'b1;
            end
            if (capture) begin
                finished_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (aluop_i)
            OP_MUL:            capture_data = product[XLEN-1:0];
            OP_MULH, OP_MULHU: capture_data = product[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:   capture_data = quotient;
            default:           capture_data = remainder;
        endcase
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result_o <= capture_data;
        end
    end

    assign stall_o = md_op && !finished_q;

    mul_iter #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) mul_iter_inst (
        .clk       (clk),
        .rst       (rst),
        .start_i   (mul_start_q),
        .signed_i  (mul_signed),
        .a_i       (oprand1_i),
        .b_i       (oprand2_i),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (product)
    );

    div_iter #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) div_iter_inst (
        .clk         (clk),
        .rst         (rst),
        .start_i     (div_start_q),
        .signed_i    (div_signed),
        .dividend_i  (oprand1_i),
        .divisor_i   (oprand2_i),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    div_start_when_idle: assert property (
        @(posedge clk) disable iff (rst) div_start_q |-> !div_busy
    );

endmodule

// ==== sim.f ====
common/ex_pkg.sv
alu/ex_alu.sv
muldiv/mul_iter.sv
muldiv/div_iter.sv
muldiv/muldiv_ctrl.sv
hdl/branch_unit.sv
hdl/ex_stage.sv
tests/ex_ref_pkg.sv
tests/tb_ex_stage.sv

// ==== tests/ex_ref_pkg.sv ====
package ex_ref_pkg;
    import ex_pkg::*;

    function automatic logic model_is_muldiv(aluop_e op);
        case (op)
            OP_MUL, OP_MULH, OP_MULHU: return 1'b1;
            OP_DIV, OP_DIVU, OP_MOD, OP_MODU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected write-back data of one instruction
    function automatic logic [XLEN-1:0] model_result(aluop_e op, logic [XLEN-1:0] pc,
                                                     logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        longint            sa;
        longint            sb;
        longint unsigned   ua;
        longint unsigned   ub;
        longint            sd;
        longint unsigned   ud;
        logic [XLEN-1:0]   dvs;
        logic [2*XLEN-1:0] wide;
        logic [4:0]        sh;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = a;
        ub = b;
        sh = b[4:0];
        // Zero divisor behaves as a divisor of one
        dvs = (b == '0) ? 32'd1 : b;
        sd = longint'($signed(dvs));
        ud = dvs;
        case (op)
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_NOR:   return ~(a | b);
            OP_SLL:   return a << sh;
            OP_SRL:   return a >> sh;
            OP_SRA: begin
                wide = {{XLEN{a[XLEN-1]}}, a} >> sh;
                return wide[XLEN-1:0];
            end
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU:  return (ua < ub) ? 32'd1 : 32'd0;
            OP_LUI:   return b;
            OP_PCADD: return pc + b;
            OP_MUL: begin
                wide = sa * sb;
                return wide[XLEN-1:0];
            end
            OP_MULH: begin
                wide = sa * sb;
                return wide[2*XLEN-1:XLEN];
            end
            OP_MULHU: begin
                wide = ua * ub;
                return wide[2*XLEN-1:XLEN];
            end
            // 64-bit math keeps the most negative dividend exact
            OP_DIV: begin
                wide = sa / sd;
                return wide[XLEN-1:0];
            end
            OP_DIVU: begin
                wide = ua / ud;
                return wide[XLEN-1:0];
            end
            OP_MOD: begin
                wide = sa % sd;
                return wide[XLEN-1:0];
            end
            OP_MODU: begin
                wide = ua % ud;
                return wide[XLEN-1:0];
            end
            OP_BL, OP_JIRL: return pc + 32'd4;
            default: return '0;
        endcase
    endfunction

    function automatic logic model_taken(aluop_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return !($signed(a) < $signed(b));
            OP_BLTU: return a < b;
            OP_BGEU: return !(a < b);
            OP_B, OP_BL, OP_JIRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_target(aluop_e op, logic [XLEN-1:0] pc,
                                                     logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                                     logic [XLEN-1:0] imm);
        if (!model_taken(op, a, b)) begin
            return pc + 32'd4;
        end
        return (op == OP_JIRL) ? a + imm : pc + imm;
    endfunction

endpackage

// ==== tests/tb_ex_stage.sv ====
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;
    import ex_ref_pkg::*;

    localparam int MULDIV_STEPS = 32;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 400;
    // Directed cases come on top of the random ones
    localparam int N_INSTR      = N_RANDOM + 10;
    localparam int WATCHDOG_NS  = (N_INSTR * (MULDIV_STEPS + 8) + RESET_CYCLES) * 10;

    logic                  clk;
    logic                  rst;
    logic                  valid_i;
    aluop_e                aluop_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       oprand1_i;
    logic [XLEN-1:0]       oprand2_i;
    logic [XLEN-1:0]       imm_i;
    logic                  wreg_i;
    logic [REG_ADDR_W-1:0] waddr_i;
    logic                  predicted_taken_i;
    logic                  advance_i;
    logic                  flush_i;
    logic                  advance_ready_o;
    logic                  out_valid_o;
    logic                  out_wreg_o;
    logic [REG_ADDR_W-1:0] out_waddr_o;
    logic [XLEN-1:0]       out_wdata_o;
    logic                  redirect_o;
    logic [XLEN-1:0]       redirect_target_o;
    int                    seed;

    ex_stage #(
        .MULDIV_STEPS (MULDIV_STEPS)
    ) ex_stage_inst (
        .clk               (clk),
        .rst               (rst),
        .valid_i           (valid_i),
        .aluop_i           (aluop_i),
        .pc_i              (pc_i),
        .oprand1_i         (oprand1_i),
        .oprand2_i         (oprand2_i),
        .imm_i             (imm_i),
        .wreg_i            (wreg_i),
        .waddr_i           (waddr_i),
        .predicted_taken_i (predicted_taken_i),
        .advance_i         (advance_i),
        .flush_i           (flush_i),
        .advance_ready_o   (advance_ready_o),
        .out_valid_o       (out_valid_o),
        .out_wreg_o        (out_wreg_o),
        .out_waddr_o       (out_waddr_o),
        .out_wdata_o       (out_wdata_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

    always #5 clk = ~clk;

    task automatic check_data(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h (op %s a 0x%h b 0x%h)",
                     name, got, exp, aluop_i.name(), oprand1_i, oprand2_i);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h (op %s)",
                     name, got, exp, aluop_i.name());
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_addr(string name, logic [REG_ADDR_W-1:0] got,
                              logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Operands biased toward corner values
    function automatic logic [XLEN-1:0] pick_operand();
        int unsigned sel;
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            0: return 32'h8000_0000;
            1: return 32'hFFFF_FFFF;
            2: return '0;
            3: return XLEN'($unsigned($random(seed)) % 16);
            default: return $random(seed);
        endcase
    endfunction

    task automatic drive_instr(aluop_e op, logic valid, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        valid_i           = valid;
        aluop_i           = op;
        pc_i              = $random(seed);
        pc_i[1:0]         = 2'b00;
        oprand1_i         = a;
        oprand2_i         = b;
        imm_i             = $random(seed);
        wreg_i            = $random(seed);
        waddr_i           = $random(seed);
        predicted_taken_i = $random(seed);
        advance_i         = 1'b0;
        flush_i           = 1'b0;
    endtask

    // One instruction from presentation to the output register
    task automatic run_instr(aluop_e op, logic valid, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                             logic flush);
        logic mispredict;
        logic loaded;
        drive_instr(op, valid, a, b);
        @(negedge clk);
        check_flag("advance_ready_o", advance_ready_o, !(valid && model_is_muldiv(op)));
        check_flag("redirect_o", redirect_o, 1'b0);
        do begin
            @(posedge clk);
            #1;
        end while (!advance_ready_o);
        advance_i = 1'b1;
        flush_i   = flush;
        @(negedge clk);
        mispredict = model_taken(op, a, b) ^ predicted_taken_i;
        check_flag("redirect_o", redirect_o, valid && mispredict);
        check_data("redirect_target_o", redirect_target_o,
                   model_target(op, pc_i, a, b, imm_i));
        @(posedge clk);
        #1;
        advance_i = 1'b0;
        flush_i   = 1'b0;
        loaded = valid && !flush;
        check_flag("out_valid_o", out_valid_o, loaded);
        check_flag("out_wreg_o", out_wreg_o, loaded && wreg_i);
        if (loaded) begin
            check_addr("out_waddr_o", out_waddr_o, waddr_i);
            check_data("out_wdata_o", out_wdata_o, model_result(op, pc_i, a, b));
        end
    endtask

    // Flush a mul/div while it is still running, with no advance
    task automatic flush_running_muldiv(aluop_e op);
        drive_instr(op, 1'b1, pick_operand(), pick_operand());
        @(negedge clk);
        check_flag("advance_ready_o", advance_ready_o, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("out_wreg_o", out_wreg_o, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the DUT never let the test finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        aluop_e          op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            valid;
        logic            flush;
        seed = 30;
        clk  = 1'b0;
        rst  = 1'b1;
        drive_instr(OP_NOP, 1'b0, '0, '0);
        predicted_taken_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag("advance_ready_o", advance_ready_o, 1'b1);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("out_wreg_o", out_wreg_o, 1'b0);
        check_flag("redirect_o", redirect_o, 1'b0);
        @(posedge clk);
        #1;

        // Directed divide corners
        run_instr(OP_DIV, 1'b1, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
        run_instr(OP_DIVU, 1'b1, 32'hDEAD_BEEF, 32'h0, 1'b0);
        run_instr(OP_MOD, 1'b1, 32'hFFFF_FFF9, 32'h0, 1'b0);
        run_instr(OP_MODU, 1'b1, 32'h8000_0000, 32'h7, 1'b0);

        // Flush paths, then a mul/div on the same unit that must still complete
        run_instr(OP_ADD, 1'b1, 32'h1234_5678, 32'h1111_1111, 1'b1);
        flush_running_muldiv(OP_DIV);
        run_instr(OP_MOD, 1'b1, 32'hFFFF_FF00, 32'h0000_0013, 1'b0);
        flush_running_muldiv(OP_MUL);
        run_instr(OP_MULH, 1'b1, 32'h8000_0000, 32'h8000_0001, 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            op = aluop_e'($unsigned($random(seed)) % 30);
            a  = pick_operand();
            b  = pick_operand();
            if ($unsigned($random(seed)) % 4 == 0) begin
                b = a;
            end
            valid = model_is_muldiv(op) || ($unsigned($random(seed)) % 8 != 0);
            flush = $unsigned($random(seed)) % 32 == 0;
            run_instr(op, valid, a, b, flush);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
